// File: hdl/interp_pkg.sv
package interp_pkg;

    // data format, signed with 7 fraction bits
    localparam int word_w    = 16;
    localparam int addr_w    = 16;
    localparam int frac_bits = 7;

    // one extra bit so k can reach 1.0
    localparam int k_w = frac_bits + 1;

    // lanes
    localparam int num_lanes  = 4;
    localparam int lane_idx_w = 2;

    // memory map
    localparam logic [addr_w-1:0] m_addr    = 16'd0;
    localparam logic [addr_w-1:0] t0_addr   = 16'd1;
    localparam logic [addr_w-1:0] t1_addr   = 16'd2;
    localparam logic [addr_w-1:0] u0_base   = 16'd10;
    localparam logic [addr_w-1:0] u1_offset = 16'd512;

    // iteration counts of the serial units
    localparam int mul_cycles = k_w;
    localparam int div_cycles = k_w;

    // sequencer FSM states
    localparam logic [2:0] st_idle      = 3'd0;
    localparam logic [2:0] st_constants = 3'd1;
    localparam logic [2:0] st_divide    = 3'd2;
    localparam logic [2:0] st_fetch     = 3'd3;
    localparam logic [2:0] st_dispatch  = 3'd4;

endpackage

// File: hdl/lane_if.sv
`timescale 1ns/100ps

interface lane_if;

    logic                          issue;
    logic [interp_pkg::word_w-1:0] u0_val;
    logic [interp_pkg::word_w-1:0] u1_val;
    logic [interp_pkg::k_w-1:0]    k_val;
    logic                          busy;
    logic                          res_valid;
    logic [interp_pkg::word_w-1:0] res_val;

    modport sequencer (
        output issue,
        output u0_val,
        output u1_val,
        output k_val,
        input  busy
    );

    modport lane (
        input  issue,
        input  u0_val,
        input  u1_val,
        input  k_val,
        output busy,
        output res_valid,
        output res_val
    );

    modport writer (
        input res_valid,
        input res_val
    );

endinterface

// File: hdl/frac_divider.sv
`timescale 1ns/100ps

module frac_divider (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          start,
    input  logic [interp_pkg::word_w-1:0] num,
    input  logic [interp_pkg::word_w-1:0] den,
    output logic [interp_pkg::k_w-1:0]    quot,
    output logic                          done
);

    logic [interp_pkg::word_w:0]               rem;
    logic [interp_pkg::word_w-1:0]             den_q;
    logic [interp_pkg::word_w+1:0]             trial;
    logic [$clog2(interp_pkg::div_cycles)-1:0] cnt;
    logic                                      running;
    logic                                      q_bit;

    // trial subtract, a clear sign bit means den fits
    assign trial = {1'b0, rem} - {2'b00, den_q};
    assign q_bit = ~trial[interp_pkg::word_w+1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running <= 1'b0;
            cnt     <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                cnt     <= '0;
            end else if (running) begin
                cnt <= cnt + 1'b1;
                if (int'(cnt) == interp_pkg::div_cycles - 1) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    // first step weighs 2^frac_bits, so no pre-shift of num
    always_ff @(posedge clk) begin
        if (start) begin
            rem   <= {1'b0, num};
            den_q <= den;
            quot  <= '0;
        end else if (running) begin
            quot <= {quot[interp_pkg::k_w-2:0], q_bit};
            if (q_bit) begin
                rem <= {trial[interp_pkg::word_w-1:0], 1'b0};
            end else begin
                rem <= {rem[interp_pkg::word_w-1:0], 1'b0};
            end
        end
    end

    den_nonzero_a: assert property (@(posedge clk) disable iff (!arst_n)
        start |-> den != '0);

endmodule

// File: hdl/interp_sequencer.sv
`timescale 1ns/100ps

module interp_sequencer (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          start_sg,
    input  logic [interp_pkg::word_w-1:0] tk_port,
    input  logic [interp_pkg::addr_w-1:0] uk_port,
    output logic [interp_pkg::addr_w-1:0] ram_add1,
    output logic [interp_pkg::addr_w-1:0] ram_add2,
    input  logic [interp_pkg::word_w-1:0] ram_data1,
    input  logic [interp_pkg::word_w-1:0] ram_data2,
    output logic                          job_start,
    output logic [interp_pkg::addr_w-1:0] job_base,
    output logic [interp_pkg::word_w-1:0] job_count,
    lane_if.sequencer                     lanes [interp_pkg::num_lanes]
);

    logic [2:0]                            state;
    logic [1:0]                            phase;
    logic [interp_pkg::word_w-1:0]         tk_q;
    logic [interp_pkg::word_w-1:0]         t0_q;
    logic [interp_pkg::word_w-1:0]         t1_q;
    logic [interp_pkg::word_w-1:0]         m_q;
    logic [interp_pkg::addr_w-1:0]         base_q;
    logic [interp_pkg::k_w-1:0]            k_q;
    logic [interp_pkg::addr_w-1:0]         idx;
    logic [interp_pkg::lane_idx_w-1:0]     ptr;
    logic [interp_pkg::num_lanes-1:0]      busy_vec;
    logic [interp_pkg::num_lanes-1:0]      issue_vec;
    logic                                  div_start;
    logic                                  div_done;
    logic [interp_pkg::k_w-1:0]            div_quot;
    logic [interp_pkg::word_w-1:0]         div_num;
    logic [interp_pkg::word_w-1:0]         div_den;
    logic                                  last_elem;

    assign div_num   = tk_q - t0_q;
    assign div_den   = t1_q - t0_q;
    assign div_start = (state == interp_pkg::st_divide) && (phase == 2'd0);
    assign last_elem = (idx + 1'b1) == m_q;

    // k is known once the divider finishes
    assign job_start = div_done;
    assign job_base  = base_q;
    assign job_count = m_q;

    frac_divider u_div (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (div_start),
        .num    (div_num),
        .den    (div_den),
        .quot   (div_quot),
        .done   (div_done)
    );

    // m and t0 together, then t1
    always_comb begin
        ram_add1 = interp_pkg::u0_base + idx;
        ram_add2 = interp_pkg::u0_base + interp_pkg::u1_offset + idx;
        if (state == interp_pkg::st_constants) begin
            ram_add1 = interp_pkg::m_addr;
            ram_add2 = (phase == 2'd0) ? interp_pkg::t0_addr : interp_pkg::t1_addr;
        end
    end

    for (genvar g = 0; g < interp_pkg::num_lanes; g++) begin : g_lane_ctl
        assign busy_vec[g]  = lanes[g].busy;
        assign issue_vec[g] = (state == interp_pkg::st_dispatch) && (ptr == g) && !busy_vec[g];

        assign lanes[g].issue  = issue_vec[g];
        assign lanes[g].u0_val = ram_data1;
        assign lanes[g].u1_val = ram_data2;
        assign lanes[g].k_val  = k_q;

        // issued lane must take the pair right away
        issue_free_a: assert property (@(posedge clk) disable iff (!arst_n)
            issue_vec[g] |=> busy_vec[g]);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= interp_pkg::st_idle;
            phase <= 2'd0;
            idx   <= '0;
            ptr   <= '0;
        end else begin
            case (state)
                interp_pkg::st_idle: begin
                    if (start_sg) begin
                        state <= interp_pkg::st_constants;
                        phase <= 2'd0;
                    end
                end
                interp_pkg::st_constants: begin
                    phase <= phase + 1'b1;
                    if (phase == 2'd2) begin
                        state <= interp_pkg::st_divide;
                        phase <= 2'd0;
                    end
                end
                interp_pkg::st_divide: begin
                    phase <= 2'd1;
                    if (div_done) begin
                        idx   <= '0;
                        ptr   <= '0;
                        state <= (m_q == '0) ? interp_pkg::st_idle : interp_pkg::st_fetch;
                    end
                end
                interp_pkg::st_fetch: begin
                    state <= interp_pkg::st_dispatch;
                end
                interp_pkg::st_dispatch: begin
                    // wait here while the target lane is busy
                    if (|issue_vec) begin
                        ptr   <= ptr + 1'b1;
                        idx   <= idx + 1'b1;
                        state <= last_elem ? interp_pkg::st_idle : interp_pkg::st_fetch;
                    end
                end
                default: state <= interp_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == interp_pkg::st_idle && start_sg) begin
            tk_q   <= tk_port;
            base_q <= uk_port;
        end
        if (state == interp_pkg::st_constants && phase == 2'd1) begin
            m_q  <= ram_data1;
            t0_q <= ram_data2;
        end
        if (state == interp_pkg::st_constants && phase == 2'd2) begin
            t1_q <= ram_data2;
        end
        if (div_done) begin
            k_q <= div_quot;
        end
    end

endmodule

// File: hdl/lerp_lane.sv
`timescale 1ns/100ps

module lerp_lane (
    input logic  clk,
    input logic  arst_n,
    lane_if.lane lane
);

    logic signed [interp_pkg::word_w:0]                   diff;
    logic signed [interp_pkg::word_w+interp_pkg::k_w:0]   mcand;
    logic signed [interp_pkg::word_w+interp_pkg::k_w:0]   acc;
    logic signed [interp_pkg::word_w+interp_pkg::k_w:0]   acc_next;
    logic signed [interp_pkg::word_w+interp_pkg::k_w:0]   scaled;
    logic [interp_pkg::k_w-1:0]                           mplier;
    logic [interp_pkg::word_w-1:0]                        u0_q;
    logic [$clog2(interp_pkg::mul_cycles)-1:0]            cnt;
    logic                                                 last;

    // 17 bits so the slope never wraps
    assign diff = signed'({lane.u1_val[interp_pkg::word_w-1], lane.u1_val})
                - signed'({lane.u0_val[interp_pkg::word_w-1], lane.u0_val});

    assign acc_next = mplier[0] ? acc + mcand : acc;
    assign scaled   = acc_next >>> interp_pkg::frac_bits;
    assign last     = int'(cnt) == interp_pkg::mul_cycles - 1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lane.busy      <= 1'b0;
            lane.res_valid <= 1'b0;
            cnt            <= '0;
        end else begin
            lane.res_valid <= 1'b0;
            if (lane.issue) begin
                lane.busy <= 1'b1;
                cnt       <= '0;
            end else if (lane.busy) begin
                cnt <= cnt + 1'b1;
                if (last) begin
                    lane.busy      <= 1'b0;
                    lane.res_valid <= 1'b1;
                end
            end
        end
    end

    // shift-add, lsb of k first
    always_ff @(posedge clk) begin
        if (lane.issue) begin
            mcand  <= {{interp_pkg::k_w{diff[interp_pkg::word_w]}}, diff};
            mplier <= lane.k_val;
            acc    <= '0;
            u0_q   <= lane.u0_val;
        end else if (lane.busy) begin
            acc    <= acc_next;
            mcand  <= mcand <<< 1;
            mplier <= mplier >> 1;
            if (last) begin
                lane.res_val <= u0_q + scaled[interp_pkg::word_w-1:0];
            end
        end
    end

    no_issue_when_busy_a: assert property (@(posedge clk) disable iff (!arst_n)
        lane.issue |-> !lane.busy);

endmodule

// File: hdl/result_writer.sv
`timescale 1ns/100ps

module result_writer (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          job_start,
    input  logic [interp_pkg::addr_w-1:0] job_base,
    input  logic [interp_pkg::word_w-1:0] job_count,
    lane_if.writer                        lanes [interp_pkg::num_lanes],
    output logic                          mem_write,
    output logic [interp_pkg::addr_w-1:0] wr_add,
    output logic [interp_pkg::word_w-1:0] data_to_ram,
    output logic                          done_sg
);

    logic [interp_pkg::num_lanes-1:0]  valid_vec;
    logic [interp_pkg::word_w-1:0]     val_arr [interp_pkg::num_lanes];
    logic [interp_pkg::num_lanes-1:0]  ptr_onehot;
    logic [interp_pkg::lane_idx_w-1:0] ptr;
    logic [interp_pkg::addr_w-1:0]     base_q;
    logic [interp_pkg::word_w-1:0]     total_q;
    logic [interp_pkg::word_w-1:0]     count;
    logic                              active;
    logic                              take;
    logic                              at_last;
    logic                              last_wr;

    for (genvar g = 0; g < interp_pkg::num_lanes; g++) begin : g_collect
        assign valid_vec[g] = lanes[g].res_valid;
        assign val_arr[g]   = lanes[g].res_val;
    end

    assign ptr_onehot = {{(interp_pkg::num_lanes-1){1'b0}}, 1'b1} << ptr;
    assign take       = active && valid_vec[ptr];
    assign at_last    = (count + 1'b1) == total_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_write <= 1'b0;
            done_sg   <= 1'b0;
            last_wr   <= 1'b0;
            active    <= 1'b0;
            ptr       <= '0;
            count     <= '0;
        end else begin
            mem_write <= take;
            last_wr   <= take && at_last;
            // empty job finishes right away
            done_sg   <= last_wr || (job_start && job_count == '0);
            if (job_start) begin
                active <= job_count != '0;
                ptr    <= '0;
                count  <= '0;
            end else if (take) begin
                ptr   <= ptr + 1'b1;
                count <= count + 1'b1;
                if (at_last) begin
                    active <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (job_start) begin
            base_q  <= job_base;
            total_q <= job_count;
        end
        if (take) begin
            wr_add      <= base_q + count;
            data_to_ram <= val_arr[ptr];
        end
    end

    // results must come back in dispatch order
    in_order_a: assert property (@(posedge clk) disable iff (!arst_n)
        (valid_vec & ~ptr_onehot) == '0);

endmodule

// File: hdl/interp_top.sv
`timescale 1ns/100ps

module interp_top (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          start_sg,
    input  logic [interp_pkg::word_w-1:0] tk_port,
    input  logic [interp_pkg::addr_w-1:0] uk_port,
    output logic [interp_pkg::addr_w-1:0] ram_add1,
    output logic [interp_pkg::addr_w-1:0] ram_add2,
    input  logic [interp_pkg::word_w-1:0] ram_data1,
    input  logic [interp_pkg::word_w-1:0] ram_data2,
    output logic                          mem_write,
    output logic [interp_pkg::addr_w-1:0] wr_add,
    output logic [interp_pkg::word_w-1:0] data_to_ram,
    output logic                          done_sg
);

    logic                          job_start;
    logic [interp_pkg::addr_w-1:0] job_base;
    logic [interp_pkg::word_w-1:0] job_count;

    lane_if lanes [interp_pkg::num_lanes] ();

    interp_sequencer u_seq (
        .clk       (clk),
        .arst_n    (arst_n),
        .start_sg  (start_sg),
        .tk_port   (tk_port),
        .uk_port   (uk_port),
        .ram_add1  (ram_add1),
        .ram_add2  (ram_add2),
        .ram_data1 (ram_data1),
        .ram_data2 (ram_data2),
        .job_start (job_start),
        .job_base  (job_base),
        .job_count (job_count),
        .lanes     (lanes)
    );

    for (genvar g = 0; g < interp_pkg::num_lanes; g++) begin : g_lane
        lerp_lane u_lane (
            .clk    (clk),
            .arst_n (arst_n),
            .lane   (lanes[g])
        );
    end

    result_writer u_writer (
        .clk         (clk),
        .arst_n      (arst_n),
        .job_start   (job_start),
        .job_base    (job_base),
        .job_count   (job_count),
        .lanes       (lanes),
        .mem_write   (mem_write),
        .wr_add      (wr_add),
        .data_to_ram (data_to_ram),
        .done_sg     (done_sg)
    );

endmodule

// File: tb/ram_model.sv
`timescale 1ns/100ps

module ram_model (
    input  logic                          clk,
    input  logic [interp_pkg::addr_w-1:0] add1,
    output logic [interp_pkg::word_w-1:0] data1,
    input  logic [interp_pkg::addr_w-1:0] add2,
    output logic [interp_pkg::word_w-1:0] data2,
    input  logic                          write_en,
    input  logic [interp_pkg::addr_w-1:0] wr_add,
    input  logic [interp_pkg::word_w-1:0] wr_data
);

    localparam int depth = 1 << interp_pkg::addr_w;

    logic [interp_pkg::word_w-1:0] mem [depth];

    // every word starts with a value derived from its own address
    initial begin
        data1 = '0;
        data2 = '0;
        for (int a = 0; a < depth; a++) begin
            mem[a] = interp_pkg::word_w'(a) ^ 16'hc3a5;
        end
    end

    // read data shows up one cycle after the address
    always @(posedge clk) begin
        data1 <= mem[add1];
        data2 <= mem[add2];
    end

    always @(posedge clk) begin
        if (write_en) begin
            mem[wr_add] <= wr_data;
        end
    end

endmodule

// File: tb/interp_tb.sv
`timescale 1ns/100ps

module interp_tb;

    localparam real clk_period = 4.0;
    localparam int  seed       = 56286;
    localparam int  max_wait   = 2000;
    localparam int  max_elems  = 20;

    logic                          clk;
    logic                          arst_n;
    logic                          start_sg;
    logic [interp_pkg::word_w-1:0] tk_port;
    logic [interp_pkg::addr_w-1:0] uk_port;
    logic [interp_pkg::addr_w-1:0] ram_add1;
    logic [interp_pkg::addr_w-1:0] ram_add2;
    logic [interp_pkg::word_w-1:0] ram_data1;
    logic [interp_pkg::word_w-1:0] ram_data2;
    logic                          mem_write;
    logic [interp_pkg::addr_w-1:0] wr_add;
    logic [interp_pkg::word_w-1:0] data_to_ram;
    logic                          done_sg;

    // stimulus vectors and expected results of the running job
    logic signed [interp_pkg::word_w-1:0] u0_vec [max_elems];
    logic signed [interp_pkg::word_w-1:0] u1_vec [max_elems];
    logic [interp_pkg::word_w-1:0]        exp_words [max_elems];
    logic [interp_pkg::addr_w-1:0]        exp_base;
    int                                   exp_m;
    int                                   wr_count;
    string                                test_name;

    interp_top uut (
        .clk         (clk),
        .arst_n      (arst_n),
        .start_sg    (start_sg),
        .tk_port     (tk_port),
        .uk_port     (uk_port),
        .ram_add1    (ram_add1),
        .ram_add2    (ram_add2),
        .ram_data1   (ram_data1),
        .ram_data2   (ram_data2),
        .mem_write   (mem_write),
        .wr_add      (wr_add),
        .data_to_ram (data_to_ram),
        .done_sg     (done_sg)
    );

    ram_model ram (
        .clk      (clk),
        .add1     (ram_add1),
        .data1    (ram_data1),
        .add2     (ram_add2),
        .data2    (ram_data2),
        .write_en (mem_write),
        .wr_add   (wr_add),
        .wr_data  (data_to_ram)
    );

    always #(clk_period / 2.0) clk = ~clk;

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    // k by floor division, then u0 + (slope * k) >>> frac_bits, wrapped to a word
    function automatic logic [interp_pkg::word_w-1:0] lerp_ref(
        input logic signed [interp_pkg::word_w-1:0] u0,
        input logic signed [interp_pkg::word_w-1:0] u1,
        input int tk,
        input int t0,
        input int t1
    );
        int k;
        int prod;
        k    = ((tk - t0) * (1 << interp_pkg::frac_bits)) / (t1 - t0);
        prod = (int'(u1) - int'(u0)) * k;
        return interp_pkg::word_w'(int'(u0) + (prod >>> interp_pkg::frac_bits));
    endfunction

    // write monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (arst_n && mem_write) begin
            if (wr_count >= exp_m) begin
                $display("unexpected RAM write to address %0d during %s", wr_add, test_name);
                $display("Simulation finished: FAIL");
                $fatal(1);
            end else begin
                check_value({test_name, " address"},
                            int'(interp_pkg::addr_w'(exp_base + wr_count)), wr_add);
                check_value({test_name, " data"}, exp_words[wr_count], data_to_ram);
                wr_count = wr_count + 1;
            end
        end
        if (arst_n && done_sg) begin
            check_value({test_name, " writes before done"}, exp_m, wr_count);
        end
    end

    task automatic fill_random(input int m);
        for (int i = 0; i < m; i++) begin
            u0_vec[i] = interp_pkg::word_w'($urandom());
            u1_vec[i] = interp_pkg::word_w'($urandom());
        end
    endtask

    task automatic wait_done(input string name);
        int cycles;
        cycles = 0;
        while (!done_sg && cycles < max_wait) begin
            @(negedge clk);
            cycles++;
        end
        if (!done_sg) begin
            $display("timeout while waiting for done_sg in %s", name);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    task automatic run_job(input string name, input int m, input int t0, input int t1,
                           input int tk, input int base);
        // set up after the previous done pulse has ended
        @(posedge clk);
        #0.5;
        ram.mem[interp_pkg::m_addr]  = interp_pkg::word_w'(m);
        ram.mem[interp_pkg::t0_addr] = interp_pkg::word_w'(t0);
        ram.mem[interp_pkg::t1_addr] = interp_pkg::word_w'(t1);
        for (int i = 0; i < m; i++) begin
            ram.mem[interp_pkg::u0_base + i] = u0_vec[i];
            ram.mem[interp_pkg::u0_base + interp_pkg::u1_offset + i] = u1_vec[i];
            exp_words[i] = lerp_ref(u0_vec[i], u1_vec[i], tk, t0, t1);
        end
        test_name = name;
        exp_base  = interp_pkg::addr_w'(base);
        exp_m     = m;
        wr_count  = 0;
        start_sg = 1'b1;
        tk_port  = interp_pkg::word_w'(tk);
        uk_port  = interp_pkg::addr_w'(base);
        @(posedge clk);
        #0.5;
        start_sg = 1'b0;
        wait_done(name);
        check_value({name, " write count"}, m, wr_count);
    endtask

    initial begin
        int m;
        int t0;
        int t1;
        int tk;
        void'($urandom(seed));
        clk       = 1'b0;
        arst_n    = 1'b0;
        start_sg  = 1'b0;
        tk_port   = '0;
        uk_port   = '0;
        exp_base  = '0;
        exp_m     = 0;
        wr_count  = 0;
        test_name = "idle";
        repeat (4) @(posedge clk);
        #0.5;
        arst_n = 1'b1;

        // quiet outputs with no job
        repeat (20) begin
            @(negedge clk);
            check_value("idle mem_write", 0, mem_write);
            check_value("idle done_sg", 0, done_sg);
        end

        // end points of the interval
        fill_random(8);
        run_job("k_zero", 8, -300, 500, -300, 1200);
        run_job("k_one", 8, -300, 500, 500, 1300);

        run_job("empty", 0, 0, 100, 50, 2000);

        // back to back, random times, bases and vectors
        for (int n = 0; n < 12; n++) begin
            m  = $urandom_range(1, max_elems);
            t0 = int'($urandom_range(0, 4000)) - 2000;
            t1 = t0 + int'($urandom_range(1, 3000));
            tk = t0 + int'($urandom_range(0, t1 - t0));
            fill_random(m);
            run_job($sformatf("random_%0d", n), m, t0, t1, tk,
                    1024 + int'($urandom_range(0, 3000)));
        end

        run_job("empty_again", 0, 10, 20, 15, 3000);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: verilog.f
hdl/interp_pkg.sv
hdl/lane_if.sv
hdl/frac_divider.sv
hdl/interp_sequencer.sv
hdl/lerp_lane.sv
hdl/result_writer.sv
hdl/interp_top.sv
tb/ram_model.sv
tb/interp_tb.sv

// File: Bender.yml
package:
  name: interp_engine

sources:
  - files:
      - hdl/interp_pkg.sv
      - hdl/lane_if.sv
      - hdl/frac_divider.sv
      - hdl/interp_sequencer.sv
      - hdl/lerp_lane.sv
      - hdl/result_writer.sv
      - hdl/interp_top.sv
  - target: test
    files:
      - tb/ram_model.sv
      - tb/interp_tb.sv
